// ==== hdl/cordic_rotator.sv ====
`timescale 1ns/1ps

// Fully unrolled, fully pipelined CORDIC in rotation mode
// Rotates (x_in, y_in) by phase_in, where a full turn is 2**PHASE_W
// Outputs carry the gain CORDIC_GAIN_Q, so magnitudes above about 0.6 of
// full scale will not fit in DATA_W at the output
module cordic_rotator (
	input  logic clk,
	input  logic rst,
	input  logic signed [couple_pkg::DATA_W-1:0] x_in,
	input  logic signed [couple_pkg::DATA_W-1:0] y_in,
	input  logic [couple_pkg::PHASE_W-1:0] phase_in,
	output logic signed [couple_pkg::DATA_W-1:0] x_out,
	output logic signed [couple_pkg::DATA_W-1:0] y_out
);
	import couple_pkg::*;

	// Two fractional guard bits on both the vector and the residual angle
	localparam int GUARD = 2;
	// One more bit on top so negating the most negative input cannot overflow
	localparam int XW = DATA_W + GUARD + 1;
	localparam int ZW = PHASE_W + GUARD;

	// Arctangent of 2**-i in residual-angle counts, rounded to nearest
	function automatic logic signed [ZW-1:0] atan_step(input int i);
		real turns;
		turns = $atan(2.0 ** (-i)) / (2.0 * 3.14159265358979);
		return ZW'($rtoi(turns * (2.0 ** ZW) + 0.5));
	endfunction

	logic signed [XW-1:0] x_s [CORDIC_STAGES+1];
	logic signed [XW-1:0] y_s [CORDIC_STAGES+1];
	logic signed [ZW-1:0] z_s [CORDIC_STAGES+1];
	logic flip;
	logic signed [XW-1:0] x_ext;
	logic signed [XW-1:0] y_ext;
	logic [PHASE_W-1:0] phase_fold;

	// Phases in the second and third quadrant differ in their top two bits
	assign flip = phase_in[PHASE_W-1] ^ phase_in[PHASE_W-2];

	// Flipping the MSB adds half a turn, which the vector negation undoes
	// Afterwards the phase read as signed lies within a quarter turn of zero
	assign phase_fold = {phase_in[PHASE_W-1] ^ flip, phase_in[PHASE_W-2:0]};

	assign x_ext = {x_in[DATA_W-1], x_in, {GUARD{1'b0}}};
	assign y_ext = {y_in[DATA_W-1], y_in, {GUARD{1'b0}}};

	// Input register holds the folded vector and the starting residual
	always_ff @(posedge clk) begin
		if (rst) begin
			x_s[0] <= '0;
			y_s[0] <= '0;
			z_s[0] <= '0;
		end else begin
			x_s[0] <= flip ? -x_ext : x_ext;
			y_s[0] <= flip ? -y_ext : y_ext;
			z_s[0] <= {phase_fold, {GUARD{1'b0}}};
		end
	end

	// Each stage rotates by plus or minus atan(2**-i) toward a zero residual
	for (genvar i = 0; i < CORDIC_STAGES; i++) begin : g_stage
		localparam logic signed [ZW-1:0] ANGLE = atan_step(i);

		always_ff @(posedge clk) begin
			if (rst) begin
				x_s[i+1] <= '0;
				y_s[i+1] <= '0;
				z_s[i+1] <= '0;
			end else if (z_s[i][ZW-1]) begin
				// Residual is negative, so this step turns clockwise
				x_s[i+1] <= x_s[i] + (y_s[i] >>> i);
				y_s[i+1] <= y_s[i] - (x_s[i] >>> i);
				z_s[i+1] <= z_s[i] + ANGLE;
			end else begin
				x_s[i+1] <= x_s[i] - (y_s[i] >>> i);
				y_s[i+1] <= y_s[i] + (x_s[i] >>> i);
				z_s[i+1] <= z_s[i] - ANGLE;
			end
		end
	end

	// Drop the guard bits and the headroom bit
	// The residual angle in the last stage is simply discarded
	always_ff @(posedge clk) begin
		if (rst) begin
			x_out <= '0;
			y_out <= '0;
		end else begin
			x_out <= x_s[CORDIC_STAGES][GUARD +: DATA_W];
			y_out <= y_s[CORDIC_STAGES][GUARD +: DATA_W];
		end
	end

endmodule

// ==== hdl/couple_pkg.sv ====
package couple_pkg;

	// Drive samples, coupling magnitudes and rotator outputs all share this width
	localparam int DATA_W = 18;

	// A full turn of phase is 2**PHASE_W counts
	localparam int PHASE_W = 19;

	// Output sum carries one extra bit so the difference of two products never wraps
	localparam int PAIR_W = DATA_W + 1;

	// Unrolled rotation stages in the CORDIC
	localparam int CORDIC_STAGES = 20;

	// Input fold register, one register per stage, then the output register
	localparam int CORDIC_LAT = CORDIC_STAGES + 2;

	// From an iq-high sample at the top level to its slot_i term on pair
	localparam int PAIR_LAT = CORDIC_LAT + 4;

	// CORDIC gain of about 1.6468, scaled by 2**16
	// The rotator leaves this gain in its outputs
	localparam int CORDIC_GAIN_Q = 107922;

	// Output port slot, slot_i is marked by iq high
	typedef enum logic {
		slot_q = 1'b0,
		slot_i = 1'b1
	} slot_t;

	// One coupling table entry as the host writes it
	typedef struct packed {
		logic signed [DATA_W-1:0] magnitude;
		logic [PHASE_W-1:0] phase_offset;
	} coupling_t;

	typedef struct packed {
		logic signed [DATA_W-1:0] x;
		logic signed [DATA_W-1:0] y;
	} phasor_t;

	typedef struct packed {
		logic signed [DATA_W-1:0] re;
		logic signed [DATA_W-1:0] im;
	} cplx_t;

endpackage

// ==== hdl/coupling_phasor.sv ====
`timescale 1ns/1ps

// Per-slot coupling phasor
// Adds the slot's phase offset to the LO phase and rotates the coupling
// magnitude by that angle, giving gain * magnitude * (cos, sin)
module coupling_phasor (
	input  logic clk,
	input  logic rst,
	input  logic [couple_pkg::PHASE_W-1:0] lo_phase,
	input  logic signed [couple_pkg::DATA_W-1:0] magnitude,
	input  logic [couple_pkg::PHASE_W-1:0] phase_offset,
	output couple_pkg::phasor_t phasor
);
	import couple_pkg::*;

	logic [PHASE_W-1:0] phase_sum;
	logic signed [DATA_W-1:0] x_rot;
	logic signed [DATA_W-1:0] y_rot;

	// The sum wraps modulo a full turn, which is exactly what the rotator wants
	always_ff @(posedge clk) begin
		if (rst) begin
			phase_sum <= '0;
		end else begin
			phase_sum <= lo_phase + phase_offset;
		end
	end

	// The magnitude arrives from the table one cycle after the offset of the
	// same slot, so it already meets phase_sum at the rotator input
	// For a slot_i term lo_phase is sampled in the iq-high cycle itself
	cordic_rotator u_cordic (
		.clk(clk),
		.rst(rst),
		.x_in(magnitude),
		.y_in('0),
		.phase_in(phase_sum),
		.x_out(x_rot),
		.y_out(y_rot)
	);

	assign phasor = '{x: x_rot, y: y_rot};

endmodule

// ==== hdl/coupling_table.sv ====
`timescale 1ns/1ps

// Two-entry coupling table, one magnitude and phase offset per output slot
// Reads are registered and return one cycle after rd_slot
module coupling_table (
	input  logic clk,
	input  logic rst,
	input  logic wr_en,
	input  couple_pkg::slot_t wr_slot,
	input  couple_pkg::coupling_t wr_data,
	input  couple_pkg::slot_t rd_slot,
	output logic signed [couple_pkg::DATA_W-1:0] magnitude,
	output logic [couple_pkg::PHASE_W-1:0] phase_offset
);
	import couple_pkg::*;

	coupling_t entry [2];
	slot_t other_slot;

	// The slots alternate every cycle, so the opposite slot is the one read next
	// The offset goes through the phase adder register, which costs one cycle,
	// so reading it one slot early lines it up with the magnitude at the rotator
	assign other_slot = (rd_slot == slot_i) ? slot_q : slot_i;

	// Host writes land at the clock edge
	// A read of the same slot in that cycle still sees the old entry
	always_ff @(posedge clk) begin
		if (rst) begin
			entry[0] <= '0;
			entry[1] <= '0;
		end else if (wr_en) begin
			entry[wr_slot] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			magnitude <= '0;
			phase_offset <= '0;
		end else begin
			magnitude <= entry[rd_slot].magnitude;
			phase_offset <= entry[other_slot].phase_offset;
		end
	end

endmodule

// ==== hdl/iq_deinterleave.sv ====
`timescale 1ns/1ps

// Turns the interleaved drive stream into one steady complex number
// I comes on iq-high cycles and Q on the cycle just before it
module iq_deinterleave (
	input  logic clk,
	input  logic rst,
	input  logic iq,
	input  logic signed [couple_pkg::DATA_W-1:0] drive,
	output couple_pkg::cplx_t drive_c
);
	import couple_pkg::*;

	logic signed [DATA_W-1:0] drive_prev;
	cplx_t held;
	// Matches the rotator latency so the pair meets both slot phasors
	cplx_t align [CORDIC_LAT];

	always_ff @(posedge clk) begin
		if (rst) begin
			drive_prev <= '0;
			held <= '0;
			for (int k = 0; k < CORDIC_LAT; k++) begin
				align[k] <= '0;
			end
		end else begin
			drive_prev <= drive;
			// Latched once per pair, so it holds for the two slots that follow
			if (iq) begin
				held.re <= drive;
				held.im <= drive_prev;
			end
			align[0] <= held;
			for (int k = 1; k < CORDIC_LAT; k++) begin
				align[k] <= align[k-1];
			end
		end
	end

	assign drive_c = align[CORDIC_LAT-1];

endmodule

// ==== hdl/pair_couple.sv ====
`timescale 1ns/1ps

// Output coupling stage for an interleaved IQ drive stream
// Each slot has its own coupling magnitude and phase offset, and pair
// carries the real part of coupling phasor times drive, interleaved by slot
// The phasor branch and the drive de-interleaver run side by side and meet
// at the product stage
module pair_couple (
	input  logic clk,
	input  logic rst,
	input  logic iq,
	input  logic signed [couple_pkg::DATA_W-1:0] drive,
	input  logic [couple_pkg::PHASE_W-1:0] lo_phase,
	input  logic wr_en,
	input  couple_pkg::slot_t wr_slot,
	input  couple_pkg::coupling_t wr_data,
	output logic signed [couple_pkg::PAIR_W-1:0] pair
);
	import couple_pkg::*;

	logic signed [DATA_W-1:0] magnitude;
	logic [PHASE_W-1:0] phase_offset;
	phasor_t phasor;
	cplx_t drive_c;

	// iq doubles as the read slot, since iq high selects slot_i
	coupling_table u_table (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.wr_slot(wr_slot),
		.wr_data(wr_data),
		.rd_slot(slot_t'(iq)),
		.magnitude(magnitude),
		.phase_offset(phase_offset)
	);

	coupling_phasor u_phasor (
		.clk(clk),
		.rst(rst),
		.lo_phase(lo_phase),
		.magnitude(magnitude),
		.phase_offset(phase_offset),
		.phasor(phasor)
	);

	iq_deinterleave u_deint (
		.clk(clk),
		.rst(rst),
		.iq(iq),
		.drive(drive),
		.drive_c(drive_c)
	);

	// The slot_i term of a pair shows up PAIR_LAT cycles after its iq-high cycle
	real_product u_product (
		.clk(clk),
		.rst(rst),
		.phasor(phasor),
		.drive_c(drive_c),
		.pair(pair)
	);

endmodule

// ==== hdl/real_product.sv ====
`timescale 1ns/1ps

// Real part of phasor times drive: x*re - y*im
// Two multipliers, a scale register and a subtraction, three cycles total
module real_product (
	input  logic clk,
	input  logic rst,
	input  couple_pkg::phasor_t phasor,
	input  couple_pkg::cplx_t drive_c,
	output logic signed [couple_pkg::PAIR_W-1:0] pair
);
	import couple_pkg::*;

	logic signed [2*DATA_W-1:0] prod_x;
	logic signed [2*DATA_W-1:0] prod_y;
	logic signed [DATA_W-1:0] scale_x;
	logic signed [DATA_W-1:0] scale_y;

	// Full-precision products, registered straight out of the multipliers
	always_ff @(posedge clk) begin
		if (rst) begin
			prod_x <= '0;
			prod_y <= '0;
		end else begin
			prod_x <= phasor.x * drive_c.re;
			prod_y <= phasor.y * drive_c.im;
		end
	end

	// Keep DATA_W bits below the redundant sign bit, i.e. divide by 2**(DATA_W-1)
	// Only full-scale negative times full-scale negative can wrap here
	always_ff @(posedge clk) begin
		if (rst) begin
			scale_x <= '0;
			scale_y <= '0;
		end else begin
			scale_x <= prod_x[2*DATA_W-2:DATA_W-1];
			scale_y <= prod_y[2*DATA_W-2:DATA_W-1];
		end
	end

	// One extra output bit holds the difference without saturation
	always_ff @(posedge clk) begin
		if (rst) begin
			pair <= '0;
		end else begin
			pair <= PAIR_W'(scale_x) - PAIR_W'(scale_y);
		end
	end

endmodule

// ==== sim.f ====
hdl/couple_pkg.sv
hdl/coupling_table.sv
hdl/cordic_rotator.sv
hdl/coupling_phasor.sv
hdl/iq_deinterleave.sv
hdl/real_product.sv
hdl/pair_couple.sv
test/tb_clock.sv
test/pair_couple_assertions.sv
test/pair_couple_tb.sv

// ==== test/pair_couple_assertions.sv ====
`timescale 1ns/1ps

// Bound checker with a real-number model of the coupling stage
// Every cycle contributes one term, compared against pair PAIR_LAT edges later
module pair_couple_assertions (
	input logic clk,
	input logic rst,
	input logic iq,
	input logic signed [couple_pkg::DATA_W-1:0] drive,
	input logic [couple_pkg::PHASE_W-1:0] lo_phase,
	input logic wr_en,
	input couple_pkg::slot_t wr_slot,
	input couple_pkg::coupling_t wr_data,
	input logic signed [couple_pkg::PAIR_W-1:0] pair
);
	import couple_pkg::*;

	// Table contents as the host has written them, and the same one cycle older
	coupling_t shadow [2];
	coupling_t shadow_d1 [2];
	logic signed [DATA_W-1:0] prev_drive;
	cplx_t latched;
	real exp_pipe [PAIR_LAT];
	bit due_pipe [PAIR_LAT];
	bit zero_pipe [PAIR_LAT];
	real exp_now;
	int exp_round;
	bit value_ok;
	int check_count = 0;
	int fail_count = 0;

	// Gain times magnitude times the real part of (cos + j sin) * (re + j im), scaled down
	function automatic real reference_term(input logic signed [DATA_W-1:0] mag,
			input logic [PHASE_W-1:0] theta_cnt, input logic signed [DATA_W-1:0] re,
			input logic signed [DATA_W-1:0] im);
		real theta;
		real gain;
		theta = 6.283185307179586 * real'(theta_cnt) / (2.0 ** PHASE_W);
		gain = real'(CORDIC_GAIN_Q) / 65536.0;
		return gain * real'(mag) * ($cos(theta) * real'(re) - $sin(theta) * real'(im))
			/ (2.0 ** (DATA_W - 1));
	endfunction

	always @(posedge clk) begin : model_step
		logic signed [DATA_W-1:0] re_now;
		logic signed [DATA_W-1:0] im_now;
		logic [PHASE_W-1:0] theta;
		slot_t slot;
		if (rst) begin
			for (int k = 0; k < 2; k++) begin
				shadow[k] <= '0;
				shadow_d1[k] <= '0;
			end
			prev_drive <= '0;
			latched <= '0;
			for (int k = 0; k < PAIR_LAT; k++) begin
				exp_pipe[k] <= 0.0;
				due_pipe[k] <= 1'b0;
				zero_pipe[k] <= 1'b0;
			end
		end else begin
			// An I sample closes a pair with the Q sample just before it
			re_now = iq ? drive : latched.re;
			im_now = iq ? prev_drive : latched.im;
			slot = slot_t'(iq);
			// The offset is read one cycle ahead of the magnitude, so it sees older writes
			theta = lo_phase + shadow_d1[slot].phase_offset;
			exp_pipe[0] <= reference_term(shadow[slot].magnitude, theta, re_now, im_now);
			due_pipe[0] <= 1'b1;
			zero_pipe[0] <= (shadow[slot].magnitude == '0);
			for (int k = 1; k < PAIR_LAT; k++) begin
				exp_pipe[k] <= exp_pipe[k-1];
				due_pipe[k] <= due_pipe[k-1];
				zero_pipe[k] <= zero_pipe[k-1];
			end
			if (due_pipe[PAIR_LAT-1]) check_count <= check_count + 1;
			prev_drive <= drive;
			if (iq) latched <= '{re: drive, im: prev_drive};
			shadow_d1 <= shadow;
			if (wr_en) shadow[wr_slot] <= wr_data;
		end
	end

	always_comb begin
		exp_now = exp_pipe[PAIR_LAT-1];
		exp_round = $rtoi(exp_now >= 0.0 ? exp_now + 0.5 : exp_now - 0.5);
		// Allowed error is 4 LSB either way
		value_ok = !due_pipe[PAIR_LAT-1] ||
			((real'(pair) - exp_now) <= 4.0 && (exp_now - real'(pair)) <= 4.0);
	end

	a_pair_value: assert property (@(posedge clk) disable iff (rst) value_ok)
		else begin
			fail_count++;
			$error("[FAIL] t=%0t pair got %0d expected %0d", $time, $sampled(pair),
				$sampled(exp_round));
		end

	// A zero magnitude gives an exact zero, with no rounding residue
	a_zero_coupling: assert property (@(posedge clk) disable iff (rst)
		(due_pipe[PAIR_LAT-1] && zero_pipe[PAIR_LAT-1]) |-> (pair == '0))
		else begin
			fail_count++;
			$error("[FAIL] t=%0t pair got %0d expected 0", $time, $sampled(pair));
		end

	// The slot alignment inside the table relies on iq alternating every cycle
	a_iq_alternates: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> (iq != $past(iq)))
		else begin
			fail_count++;
			$error("iq held its value for two cycles in a row at t=%0t", $time);
		end

	a_lo_steps: assert property (@(posedge clk) disable iff (rst)
		$changed(lo_phase) |=> $stable(lo_phase))
		else begin
			fail_count++;
			$error("lo_phase changed on two cycles in a row at t=%0t", $time);
		end
endmodule

// ==== test/pair_couple_tb.sv ====
`timescale 1ns/1ps

module pair_couple_tb;
	import couple_pkg::*;

	logic clk;
	logic rst;
	logic iq = 1'b0;
	logic signed [DATA_W-1:0] drive = '0;
	logic [PHASE_W-1:0] lo_phase = '0;
	logic wr_en;
	slot_t wr_slot;
	coupling_t wr_data;
	logic signed [PAIR_W-1:0] pair;

	// Stream shape, changed by the tests between phases
	bit rand_drive = 1'b0;
	bit rand_lo = 1'b0;
	logic signed [DATA_W-1:0] drive_i = '0;
	logic signed [DATA_W-1:0] drive_q = '0;
	logic [PHASE_W-1:0] lo_level = '0;
	int seed = 32'hb17d_d52f;
	int failed_tests = 0;

	tb_clock u_clock (.clk(clk), .rst(rst));

	pair_couple dut0 (
		.clk(clk), .rst(rst), .iq(iq), .drive(drive), .lo_phase(lo_phase),
		.wr_en(wr_en), .wr_slot(wr_slot), .wr_data(wr_data), .pair(pair)
	);

	bind pair_couple pair_couple_assertions u_checks (
		.clk(clk), .rst(rst), .iq(iq), .drive(drive), .lo_phase(lo_phase),
		.wr_en(wr_en), .wr_slot(wr_slot), .wr_data(wr_data), .pair(pair)
	);

	// Continuous stream, iq toggles every cycle and lo_phase only steps on I cycles
	always @(posedge clk) begin
		if (rst) begin
			iq <= 1'b0;
		end else begin
			iq <= ~iq;
			if (rand_drive) drive <= DATA_W'($random(seed));
			else drive <= iq ? drive_q : drive_i;
			if (!iq) lo_phase <= rand_lo ? PHASE_W'($random(seed)) : lo_level;
		end
	end

	task automatic write_coupling(input slot_t slot, input logic signed [DATA_W-1:0] mag,
			input logic [PHASE_W-1:0] offset);
		@(posedge clk);
		wr_en <= 1'b1;
		wr_slot <= slot;
		wr_data <= '{magnitude: mag, phase_offset: offset};
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	// Waits until the checker has compared count more outputs, or gives up
	task automatic wait_checks(input int count, output bit timed_out);
		int target;
		int cycles;
		target = dut0.u_checks.check_count + count;
		cycles = 0;
		while (dut0.u_checks.check_count < target && cycles < count + 4 * PAIR_LAT) begin
			@(posedge clk);
			cycles++;
		end
		timed_out = (dut0.u_checks.check_count < target);
	endtask

	task automatic report_test(input int number, input string name, input int errors_before,
			input bit timed_out);
		int errors;
		errors = dut0.u_checks.fail_count - errors_before;
		if (timed_out) begin
			failed_tests++;
			$display("test %0d %s: output checks stopped advancing before the end", number, name);
		end else if (errors != 0) begin
			failed_tests++;
			$display("test %0d %s: %0d errors", number, name, errors);
		end else begin
			$display("test %0d %s: ok", number, name);
		end
	endtask

	initial begin
		int errors_before;
		bit timed_out;
		bit any_timeout;
		wr_en = 1'b0;
		wr_slot = slot_q;
		wr_data = '0;

		// Both magnitudes are zero from reset, so any stream gives zero
		errors_before = 0;
		rand_drive <= 1'b1;
		rand_lo <= 1'b1;
		wait_checks(80, timed_out);
		report_test(1, "zero coupling after reset", errors_before, timed_out);

		errors_before = dut0.u_checks.fail_count;
		rand_drive <= 1'b0;
		rand_lo <= 1'b0;
		lo_level <= 19'h12345;
		drive_i <= 18'sd40000;
		drive_q <= -18'sd25000;
		write_coupling(slot_i, 18'sd50000, '0);
		write_coupling(slot_q, -18'sd30000, '0);
		wait_checks(80, timed_out);
		report_test(2, "fixed phase and constant drive", errors_before, timed_out);

		// Same magnitude as slot_i and half a turn apart, so slot_q mirrors slot_i
		errors_before = dut0.u_checks.fail_count;
		write_coupling(slot_q, 18'sd50000, 19'h40000);
		wait_checks(80, timed_out);
		report_test(3, "half turn offset on slot_q", errors_before, timed_out);

		errors_before = dut0.u_checks.fail_count;
		write_coupling(slot_i, 18'sd20000, 19'h01000);
		wait_checks(80, timed_out);
		report_test(4, "rewrite of slot_i only", errors_before, timed_out);

		// Magnitudes stay below about 0.6 of full scale so the rotator output fits
		errors_before = dut0.u_checks.fail_count;
		any_timeout = 1'b0;
		rand_drive <= 1'b1;
		rand_lo <= 1'b1;
		for (int k = 0; k < 24; k++) begin
			write_coupling(slot_t'(1'($random(seed))), DATA_W'($random(seed) % 79000),
				PHASE_W'($random(seed)));
			wait_checks(16, timed_out);
			any_timeout |= timed_out;
		end
		// An eighth of a turn with opposite full-scale I and Q drives pair past DATA_W
		rand_drive <= 1'b0;
		rand_lo <= 1'b0;
		lo_level <= '0;
		drive_i <= 18'sd131071;
		drive_q <= -18'sd131071;
		write_coupling(slot_i, 18'sd79000, 19'h10000);
		write_coupling(slot_q, 18'sd79000, 19'h10000);
		wait_checks(80, timed_out);
		any_timeout |= timed_out;
		report_test(5, "random stream and near full scale", errors_before, any_timeout);

		$display("tests run 5, tests failed %0d, check errors %0d", failed_tests,
			dut0.u_checks.fail_count);
		if (failed_tests == 0 && dut0.u_checks.fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end
endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

// Free-running 100 ns clock and a reset held high for the first 4 rising edges
module tb_clock (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset drops on the 4th rising edge, like any other driven input
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end
endmodule
